//--- verilog/drbg_pkg.sv
// Shared types and constants for the DRBG
// Word, counter, mask and length types, controller state enum
// Mixing constants and the K and V start values

package drbg_pkg;

  // ----------------------------------------
  // Widths with a meaning
  // ----------------------------------------
  typedef logic [31:0] word_t;     // K, V, T, entropy, nonce, tags
  typedef logic [7:0]  cnt_t;      // Update counter, low byte of counter word
  typedef logic [15:0] mask_t;     // LFSR word
  typedef logic [2:0]  msg_len_t;  // Valid message words, 1 to 4

  // Controller sequence
  typedef enum logic [3:0] {
    idle,     // Wait for a command
    init,     // Load K and V start values
    next,     // Bump counter for a fresh update
    k1,       // K = mac(K, V || cnt || entropy || nonce)
    v1,       // V = mac(K, V)
    k2_prep,  // Second counter bump
    k2,       // K = mac(K, V || cnt || entropy || nonce)
    v2,       // V = mac(K, V)
    t,        // T = V = mac(K, V)
    check,    // Range check on T
    k3,       // K = mac(K, V || 0)
    v3,       // V = mac(K, V)
    done      // Publish T
  } drbg_state_e;

  // ----------------------------------------
  // Start values and mixing constants
  // ----------------------------------------
  localparam word_t k_init    = 32'h0000_0000;
  localparam word_t v_init    = 32'h0101_0101;
  localparam word_t mix_const = 32'h9e37_79b9;  // Golden ratio round constant
  localparam int    mix_rounds = 4;             // Rounds per message word

  // Tag rule, one round per step:
  //   state = rotl5(state ^ w) + mix_const
  // Each word gets mix_rounds steps, then the length is added

endpackage

//--- verilog/drbg_mac_if.sv
// Request and tag bundle between the DRBG controller and mac core
// Four-phase req/ack, controller and core modports

interface drbg_mac_if;
  import drbg_pkg::*;

  logic             req;   // Raised by controller, payload stable while high
  word_t            key;   // Current K
  word_t [3:0]      msg;   // Word 0 is mixed first
  msg_len_t         len;   // 1 to 4 words
  mask_t            mask;  // LFSR sample, low bits set the dummy cycles
  logic             ack;   // Raised by core with tag valid
  word_t            tag;   // Result of the keyed mix

  // Controller side
  modport ctrl (
    output req, key, msg, len, mask,
    input  ack, tag
  );

  // Core side
  modport core (
    input  req, key, msg, len, mask,
    output ack, tag
  );

endinterface

//--- verilog/drbg_mac.sv
// Multi-cycle keyed mixing core standing in for HMAC
// Dummy cycles from the mask, one round per cycle, length added last

module drbg_mac (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      zeroize,
  drbg_mac_if.core  mac
);
  import drbg_pkg::*;

  typedef enum logic [2:0] {
    core_idle,   // Wait for req
    core_dummy,  // Burn masked cycles
    core_mix,    // One round per cycle
    core_fin,    // Add length, raise ack
    core_ack     // Hold ack until req drops
  } core_state_e;

  core_state_e core_st;
  logic [1:0]  dummy_cnt;  // Remaining dummy cycles
  logic [1:0]  word_idx;   // Word being mixed
  logic [1:0]  rnd_idx;    // Round within the word
  logic        ack_q;
  word_t       mix_q;      // Running mix state
  word_t [3:0] msg_q;
  msg_len_t    len_q;
  word_t       tag_q;
  logic        last_rnd;
  logic        last_word;
  logic        take_req;

  // One mixing step
  function automatic word_t mix_round(input word_t s, input word_t w);
    word_t x;
    x = s ^ w;
    return {x[26:0], x[31:27]} + mix_const;  // Rotate left by 5, add constant
  endfunction

  assign take_req  = (core_st == core_idle) && mac.req;
  assign last_rnd  = (rnd_idx == 2'(mix_rounds - 1));
  assign last_word = (word_idx == 2'(len_q - msg_len_t'(1)));

  // ----------------------------------------
  // Sequencing and handshake
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      core_st   <= core_idle;
      dummy_cnt <= '0;
      word_idx  <= '0;
      rnd_idx   <= '0;
      ack_q     <= 1'b0;
    end else if (zeroize) begin
      core_st   <= core_idle;
      dummy_cnt <= '0;
      word_idx  <= '0;
      rnd_idx   <= '0;
      ack_q     <= 1'b0;
    end else begin
      case (core_st)
        core_idle: begin
          if (mac.req) begin
            dummy_cnt <= mac.mask[1:0];  // 0 to 3 extra cycles
            word_idx  <= '0;
            rnd_idx   <= '0;
            core_st   <= (mac.mask[1:0] == 2'd0) ? core_mix : core_dummy;
          end
        end
        core_dummy: begin
          dummy_cnt <= dummy_cnt - 2'd1;
          if (dummy_cnt == 2'd1) core_st <= core_mix;
        end
        core_mix: begin
          if (last_rnd) begin
            rnd_idx  <= '0;
            word_idx <= word_idx + 2'd1;
            if (last_word) core_st <= core_fin;  // All len x 4 rounds done
          end else begin
            rnd_idx <= rnd_idx + 2'd1;
          end
        end
        core_fin: begin
          ack_q   <= 1'b1;  // Tag valid from here
          core_st <= core_ack;
        end
        core_ack: begin
          if (!mac.req) begin
            ack_q   <= 1'b0;  // Falls one cycle after req
            core_st <= core_idle;
          end
        end
        default: core_st <= core_idle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (take_req) begin
      mix_q <= mac.key;  // State starts at key
      msg_q <= mac.msg;
      len_q <= mac.len;
    end else if (core_st == core_mix) begin
      mix_q <= mix_round(mix_q, msg_q[word_idx]);
    end
    if (core_st == core_fin) tag_q <= mix_q + word_t'(len_q);
  end

  assign mac.ack = ack_q;
  assign mac.tag = tag_q;

endmodule

//--- verilog/drbg_lfsr.sv
// Free-running 16-bit Galois LFSR for the timing mask
// Reseeded by xor on init_cmd, never left at zero

module drbg_lfsr #(
  parameter drbg_pkg::mask_t lfsr_init_seed = 16'hace1
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            zeroize,
  input  logic            init_cmd,
  input  drbg_pkg::mask_t lfsr_seed,
  output drbg_pkg::mask_t mask
);
  import drbg_pkg::*;

  localparam mask_t taps = 16'hb400;
  // Zero seed would lock the register
  localparam mask_t start_seed = (lfsr_init_seed == '0) ? mask_t'(1) : lfsr_init_seed;

  mask_t lfsr_q;
  mask_t stepped;
  mask_t reseeded;

  assign stepped  = lfsr_q[0] ? ((lfsr_q >> 1) ^ taps) : (lfsr_q >> 1);
  assign reseeded = lfsr_q ^ lfsr_seed;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      lfsr_q <= start_seed;
    end else if (zeroize) begin
      lfsr_q <= start_seed;
    end else if (init_cmd) begin
      lfsr_q <= (reseeded == '0) ? start_seed : reseeded;  // Avoid all-zero
    end else begin
      lfsr_q <= stepped;  // Step every cycle
    end
  end

  assign mask = lfsr_q;

endmodule

//--- verilog/drbg_ctrl.sv
// DRBG controller FSM
// Holds K, V and the counter, builds mac requests, range-checks T
// Owns ready, valid and drbg

module drbg_ctrl #(
  parameter drbg_pkg::word_t drbg_limit = 32'hfffe_ffff
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            zeroize,
  input  logic            init_cmd,
  input  logic            next_cmd,
  input  drbg_pkg::word_t entropy,
  input  drbg_pkg::word_t nonce,
  input  drbg_pkg::mask_t mask,
  drbg_mac_if.ctrl        mac,
  output logic            ready,
  output logic            valid,
  output drbg_pkg::word_t drbg
);
  import drbg_pkg::*;

  drbg_state_e state_q;
  drbg_state_e state_d;
  word_t       k_q;
  word_t       v_q;        // Also T after the t step
  cnt_t        cnt_q;
  word_t       entropy_q;  // Captured with the command
  word_t       nonce_q;
  word_t       cnt_word;
  mask_t       mask_q;
  logic        req_q;
  logic        accept;
  logic        is_mac;
  logic        start_req;
  logic        tag_in;
  logic        t_ok;

  assign accept    = (state_q == idle) && ready && (init_cmd ^ next_cmd);  // Both high is ignored
  assign is_mac    = state_q inside {k1, v1, k2, v2, t, k3, v3};
  assign start_req = is_mac && !req_q && !mac.ack;  // Previous ack must be gone
  assign tag_in    = req_q && mac.ack;
  assign t_ok      = (v_q != '0) && (v_q <= drbg_limit);
  assign cnt_word  = word_t'(cnt_q);  // Counter in low byte

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      idle:    if (accept) state_d = init_cmd ? init : next;
      init:    state_d = k1;
      next:    state_d = k1;
      k1:      if (tag_in) state_d = v1;
      v1:      if (tag_in) state_d = k2_prep;
      k2_prep: state_d = k2;
      k2:      if (tag_in) state_d = v2;
      v2:      if (tag_in) state_d = t;
      t:       if (tag_in) state_d = check;
      check:   state_d = t_ok ? done : k3;  // Reject zero or above limit
      k3:      if (tag_in) state_d = v3;
      v3:      if (tag_in) state_d = t;     // Retry with reseeded K, V
      done:    state_d = idle;
      default: state_d = idle;
    endcase
  end

  // Message per step, word 0 first
  always_comb begin
    mac.msg = '0;
    mac.len = msg_len_t'(1);
    case (state_q)
      k1, k2: begin
        mac.msg = {nonce_q, entropy_q, cnt_word, v_q};
        mac.len = msg_len_t'(4);
      end
      k3: begin
        mac.msg[0] = v_q;  // Followed by the zero word
        mac.len    = msg_len_t'(2);
      end
      default: mac.msg[0] = v_q;
    endcase
  end

  // ----------------------------------------
  // FSM, req and ready
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= idle;
      req_q   <= 1'b0;
      ready   <= 1'b0;
    end else if (zeroize) begin
      state_q <= idle;
      req_q   <= 1'b0;
      ready   <= 1'b0;
    end else begin
      state_q <= state_d;
      ready   <= (state_q == idle) && !accept;  // High a cycle after idle entry
      if (start_req) req_q <= 1'b1;
      else if (tag_in) req_q <= 1'b0;  // Tag captured this edge
    end
  end

  // Outputs hold until the next accepted command
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid <= 1'b0;
      drbg  <= '0;
    end else if (zeroize) begin
      valid <= 1'b0;
      drbg  <= '0;
    end else if (accept) begin
      valid <= 1'b0;
    end else if (state_q == done) begin
      valid <= 1'b1;
      drbg  <= v_q;
    end
  end

  // K, V and counter
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      k_q   <= '0;
      v_q   <= '0;
      cnt_q <= '0;
    end else if (zeroize) begin
      k_q   <= '0;
      v_q   <= '0;
      cnt_q <= '0;
    end else begin
      case (state_q)
        init: begin
          k_q   <= k_init;
          v_q   <= v_init;
          cnt_q <= '0;
        end
        next, k2_prep:  cnt_q <= cnt_q + cnt_t'(1);
        k1, k2, k3:     if (tag_in) k_q <= mac.tag;
        v1, v2, v3, t:  if (tag_in) v_q <= mac.tag;
        default:        cnt_q <= cnt_q;
      endcase
    end
  end

  // Command inputs and per-request mask
  always_ff @(posedge clk) begin
    if (accept) begin
      entropy_q <= entropy;
      nonce_q   <= nonce;
    end
    if (start_req) mask_q <= mask;  // Fresh LFSR sample per request
  end

  assign mac.req  = req_q;
  assign mac.key  = k_q;
  assign mac.mask = mask_q;

endmodule

//--- verilog/drbg_top.sv
// DRBG top level
// Controller, mac core and mask LFSR joined by the mac interface

module drbg_top #(
  parameter drbg_pkg::word_t drbg_limit     = 32'hfffe_ffff,
  parameter drbg_pkg::mask_t lfsr_init_seed = 16'hace1
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            zeroize,
  input  logic            init_cmd,
  input  logic            next_cmd,
  input  drbg_pkg::mask_t lfsr_seed,
  input  drbg_pkg::word_t entropy,
  input  drbg_pkg::word_t nonce,
  output logic            ready,
  output logic            valid,
  output drbg_pkg::word_t drbg
);
  import drbg_pkg::*;

  mask_t mask;  // LFSR word into the controller

  drbg_mac_if mac_if ();

  drbg_ctrl #(
    .drbg_limit (drbg_limit)
  ) drbg_ctrl_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .zeroize  (zeroize),
    .init_cmd (init_cmd),
    .next_cmd (next_cmd),
    .entropy  (entropy),
    .nonce    (nonce),
    .mask     (mask),
    .mac      (mac_if),
    .ready    (ready),
    .valid    (valid),
    .drbg     (drbg)
  );

  drbg_mac drbg_mac_i (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .mac     (mac_if)
  );

  drbg_lfsr #(
    .lfsr_init_seed (lfsr_init_seed)
  ) drbg_lfsr_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .init_cmd  (init_cmd),
    .lfsr_seed (lfsr_seed),
    .mask      (mask)
  );

endmodule

//--- include/drbg_ref.svh
// Reference model for the DRBG testbench
// Keyed mix function and the instantiate/next/generate sequence

`ifndef DRBG_REF_SVH
`define DRBG_REF_SVH

// Keyed mix over len words, msg[0] first
function automatic drbg_pkg::word_t keyed_mix(input drbg_pkg::word_t key,
                                              input logic [3:0][31:0] msg, input int len);
  drbg_pkg::word_t s;
  drbg_pkg::word_t x;
  s = key;
  for (int i = 0; i < len; i++) begin
    for (int r = 0; r < drbg_pkg::mix_rounds; r++) begin
      x = s ^ msg[i];
      s = {x[26:0], x[31:27]} + drbg_pkg::mix_const;
    end
  end
  return s + drbg_pkg::word_t'(len);
endfunction

// One instantiate or next, returns the accepted T
function automatic drbg_pkg::word_t predict_t(inout drbg_pkg::word_t k, inout drbg_pkg::word_t v,
                                              inout drbg_pkg::cnt_t cnt, input bit inst,
                                              input drbg_pkg::word_t entropy,
                                              input drbg_pkg::word_t nonce,
                                              input drbg_pkg::word_t limit);
  drbg_pkg::word_t cw;
  if (inst) begin
    k   = drbg_pkg::k_init;
    v   = drbg_pkg::v_init;
    cnt = '0;
  end else begin
    cnt = cnt + 8'd1;
  end
  for (int pass = 0; pass < 2; pass++) begin
    if (pass == 1) cnt = cnt + 8'd1;   // k2_prep bump
    cw = {24'h0, cnt};
    k  = keyed_mix(k, {nonce, entropy, cw, v}, 4);
    v  = keyed_mix(k, {96'h0, v}, 1);
  end
  v = keyed_mix(k, {96'h0, v}, 1);       // Candidate T
  while (v == '0 || v > limit) begin
    k = keyed_mix(k, {96'h0, v}, 2);     // V then zero word
    v = keyed_mix(k, {96'h0, v}, 1);
    v = keyed_mix(k, {96'h0, v}, 1);
  end
  return v;
endfunction

`endif

//--- bench/drbg_tb.sv
// Testbench for the DRBG top level
// Clock, reset, command stimulus, compare process, timeout and summary

module drbg_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import drbg_pkg::*;

  `include "drbg_ref.svh"

  localparam word_t tb_limit   = 32'h3fff_ffff;  // Low limit, most candidates rejected
  localparam int    max_cycles = 20000;          // Generous bound for about 15 commands

  logic  clk;
  logic  reset_n;
  logic  zeroize;
  logic  init_cmd;
  logic  next_cmd;
  mask_t lfsr_seed;
  word_t entropy;
  word_t nonce;
  logic  ready;
  logic  valid;
  word_t drbg;

  word_t m_k = '0;        // Model K
  word_t m_v = '0;        // Model V
  cnt_t  m_cnt = '0;      // Model counter
  word_t exp_drbg = '0;   // Expected T of the command in flight
  int    errors = 0;
  int    checks = 0;
  int    results = 0;     // Rising edges of valid seen
  int    cycles = 0;
  logic  valid_q = 1'b0;

  drbg_top #(
    .drbg_limit (tb_limit)
  ) drbg_top_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .init_cmd  (init_cmd),
    .next_cmd  (next_cmd),
    .lfsr_seed (lfsr_seed),
    .entropy   (entropy),
    .nonce     (nonce),
    .ready     (ready),
    .valid     (valid),
    .drbg      (drbg)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: run stopped after %0d cycles, a result never arrived", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Compare process, mid-cycle sampling
  // ----------------------------------------
  always @(negedge clk) begin
    if (valid && !valid_q) begin
      checks++;
      results++;
      if (drbg !== exp_drbg) begin
        errors++;
        $display("FAILED @%0t: drbg %h, model %h", $time, drbg, exp_drbg);
      end
      if (drbg == '0 || drbg > tb_limit) begin
        errors++;
        $display("FAILED @%0t: drbg %h outside 1..%h", $time, drbg, tb_limit);
      end
    end
    valid_q <= valid;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED @%0t: %s", $time, msg);
  endtask

  // One cycle, then the stimulus offset
  task automatic step;
    @(posedge clk);
    #2;
  endtask

  // Wait for ready, run the model, pulse the command for one cycle
  task automatic send_cmd(input bit inst, input word_t e, input word_t n);
    while (!ready) step();
    entropy  = e;
    nonce    = n;
    exp_drbg = predict_t(m_k, m_v, m_cnt, inst, e, n, tb_limit);
    init_cmd = inst;
    next_cmd = !inst;
    step();
    init_cmd = 1'b0;
    next_cmd = 1'b0;
  endtask

  // Block until the compare process has seen a new result
  task automatic wait_result;
    int seen;
    seen = results;
    while (results == seen) step();
  endtask

  // valid and drbg must stay at the model's T while no command comes
  task automatic check_hold(input int n);
    for (int i = 0; i < n; i++) begin
      step();
      checks++;
      if (!valid || drbg !== exp_drbg)
        report_error("valid or drbg changed before a new command");
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    word_t e0;
    word_t n0;
    word_t first_t;
    void'($urandom(32'h9f47_ada9));  // Fixed seed
    reset_n   = 1'b0;
    zeroize   = 1'b0;
    init_cmd  = 1'b0;
    next_cmd  = 1'b0;
    lfsr_seed = '0;
    entropy   = '0;
    nonce     = '0;
    repeat (2) @(posedge clk);
    #2;
    reset_n = 1'b1;

    // Reset state, then ready within a few cycles
    checks++;
    if (valid || drbg !== '0) report_error("valid or drbg not clear after reset");
    for (int i = 0; i < 5 && !ready; i++) step();
    checks++;
    if (!ready) report_error("ready did not rise after reset");

    // Instantiate and hold
    lfsr_seed = mask_t'($urandom());
    send_cmd(1'b1, $urandom(), $urandom());
    wait_result();
    check_hold(5);

    // Ten generates, counter path and rejection retries
    repeat (10) begin
      send_cmd(1'b0, $urandom(), $urandom());
      wait_result();
    end

    // Command while busy is ignored
    send_cmd(1'b0, $urandom(), $urandom());
    repeat (3) step();
    checks++;
    if (ready) report_error("ready high while a generate is running");
    entropy  = $urandom();
    init_cmd = 1'b1;
    step();
    init_cmd = 1'b0;
    wait_result();

    // Zeroize in the middle of a generate
    send_cmd(1'b0, $urandom(), $urandom());
    repeat (6) step();
    zeroize = 1'b1;
    step();
    zeroize = 1'b0;
    checks++;
    if (valid || drbg !== '0) report_error("zeroize left valid or drbg set");
    send_cmd(1'b1, $urandom(), $urandom());  // Fresh model state
    wait_result();

    // Same inputs, other LFSR seed, same result
    e0 = $urandom();
    n0 = $urandom();
    lfsr_seed = mask_t'($urandom());
    send_cmd(1'b1, e0, n0);
    wait_result();
    first_t   = exp_drbg;
    lfsr_seed = ~lfsr_seed;
    send_cmd(1'b1, e0, n0);
    wait_result();
    checks++;
    if (drbg !== first_t)
      report_error($sformatf("drbg %h differs from %h with other seed", drbg, first_t));

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
verilog/drbg_pkg.sv
verilog/drbg_mac_if.sv
verilog/drbg_mac.sv
verilog/drbg_lfsr.sv
verilog/drbg_ctrl.sv
verilog/drbg_top.sv
bench/drbg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DRBG testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f filelist.f \
  --top-module drbg_tb \
  --Mdir obj_dir \
  -o drbg_sim

./obj_dir/drbg_sim | tee sim.log

# Failure is decided from the log
if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
